// File: cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk (
   input logic           clk,
   input logic           reset_n,
   input logic           i_inst_req,
   input logic           i_inst_ack,
   input logic           i_out_req,
   input cpu_pkg::word_t i_out_data,
   input logic           i_out_ack,
   input logic           i_halted
);

   // Number of failed assertions so far
   int fail_count = 0;

   //////////////////////////////
   // Instruction input
   //////////////////////////////

   // Ack only answers a pending request
   assert property (@(posedge clk) disable iff (!reset_n)
      $rose(i_inst_ack) |-> $past(i_inst_req))
      else begin
         fail_count = fail_count + 1;
         $error("instruction ack rose without a request");
      end

   //////////////////////////////
   // Output port
   //////////////////////////////

   // Req held until the sink acks
   assert property (@(posedge clk) disable iff (!reset_n)
      i_out_req && !i_out_ack |=> i_out_req)
      else begin
         fail_count = fail_count + 1;
         $error("output req dropped before ack");
      end

   // Data frozen while req is up
   assert property (@(posedge clk) disable iff (!reset_n)
      i_out_req && $past(i_out_req) |-> i_out_data == $past(i_out_data))
      else begin
         fail_count = fail_count + 1;
         $error("output data changed while req was high");
      end

   // Halt is sticky
   assert property (@(posedge clk) disable iff (!reset_n)
      i_halted |=> i_halted)
      else begin
         fail_count = fail_count + 1;
         $error("halted fell without reset");
      end

endmodule

bind cpu_core cpu_chk i_cpu_chk (
   .clk        (clk),
   .reset_n    (reset_n),
   .i_inst_req (i_inst_req),
   .i_inst_ack (o_inst_ack),
   .i_out_req  (o_out_req),
   .i_out_data (o_out_data),
   .i_out_ack  (i_out_ack),
   .i_halted   (o_halted)
);

// File: cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
   parameter int QUEUE_DEPTH = cpu_pkg::QUEUE_DEPTH_DEFAULT
) (
   input  logic           clk,
   input  logic           reset_n,
   input  logic           i_inst_req,
   input  cpu_pkg::inst_u i_inst,
   output logic           o_inst_ack,
   output logic           o_out_req,
   output cpu_pkg::word_t o_out_data,
   input  logic           i_out_ack,
   output logic           o_halted,
   output cpu_pkg::word_t o_num_inst
);

   // Decoder to queue
   logic              push_valid;
   cpu_pkg::exec_op_t push_op;
   logic              full;

   // Queue to execute unit
   logic              pop_valid;
   cpu_pkg::exec_op_t pop_op;
   logic              pop_ready;

   // Producer
   inst_decoder i_inst_decoder (
      .clk          (clk),
      .reset_n      (reset_n),
      .i_inst_req   (i_inst_req),
      .i_inst       (i_inst),
      .i_full       (full),
      .o_inst_ack   (o_inst_ack),
      .o_push_valid (push_valid),
      .o_push_op    (push_op)
   );

   // Buffer
   decode_queue #(
      .DEPTH (QUEUE_DEPTH)
   ) i_decode_queue (
      .clk          (clk),
      .reset_n      (reset_n),
      .i_push_valid (push_valid),
      .i_push_op    (push_op),
      .i_pop_ready  (pop_ready),
      .o_full       (full),
      .o_pop_valid  (pop_valid),
      .o_pop_op     (pop_op)
   );

   // Consumer, EX and WB
   exec_unit i_exec_unit (
      .clk         (clk),
      .reset_n     (reset_n),
      .i_pop_valid (pop_valid),
      .i_pop_op    (pop_op),
      .o_pop_ready (pop_ready),
      .i_out_ack   (i_out_ack),
      .o_out_req   (o_out_req),
      .o_out_data  (o_out_data),
      .o_halted    (o_halted),
      .o_num_inst  (o_num_inst)
   );

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

   //////////////////////////////
   // Basic widths
   //////////////////////////////

   // Data word of the core
   typedef logic [15:0] word_t;

   // Register number, four registers
   typedef logic [1:0] reg_idx_t;
   localparam int NUM_REGS = 4;

   // Decoded-operation queue depth unless the top level overrides it
   localparam int QUEUE_DEPTH_DEFAULT = 4;

   //////////////////////////////
   // Instruction encodings
   //////////////////////////////

   // Opcodes kept from the full ISA
   typedef enum logic [3:0] {
      OP_ADI   = 4'd4,
      OP_ORI   = 4'd5,
      OP_LHI   = 4'd6,
      OP_RTYPE = 4'd15
   } opcode_t;

   // R-type function codes
   typedef enum logic [5:0] {
      FN_ADD = 6'd0,
      FN_SUB = 6'd1,
      FN_AND = 6'd2,
      FN_ORR = 6'd3,
      FN_NOT = 6'd4,
      FN_TCP = 6'd5,
      FN_SHL = 6'd6,
      FN_SHR = 6'd7,
      FN_WWD = 6'd28,
      FN_HLT = 6'd29
   } func_t;

   // R-type layout
   typedef struct packed {
      opcode_t  opcode;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      func_t    func;
   } r_fmt_t;

   // I-type layout, low byte is the immediate
   typedef struct packed {
      opcode_t    opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      logic [7:0] imm8;
   } i_fmt_t;

   // Same word, read as R or I format by the decoder
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } inst_u;

   //////////////////////////////
   // Decoded operation
   //////////////////////////////

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_NOT,
      ALU_TCP,
      ALU_SHL,
      ALU_SHR,
      ALU_PASS_B
   } alu_op_t;

   // One entry of the decode queue
   typedef struct packed {
      alu_op_t  alu_op;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t write_reg;
      logic     reg_write;
      logic     use_imm;    // ALU operand B from imm instead of rt
      word_t    imm;        // already extended or shifted
      logic     is_output;  // WWD
      logic     is_halt;    // HLT
   } exec_op_t;

endpackage

// File: decode_queue.sv
`timescale 1ns/1ps

module decode_queue #(
   parameter int DEPTH = 4
) (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              i_push_valid,
   input  cpu_pkg::exec_op_t i_push_op,
   input  logic              i_pop_ready,
   output logic              o_full,
   output logic              o_pop_valid,
   output cpu_pkg::exec_op_t o_pop_op
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Storage
   cpu_pkg::exec_op_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   logic push;
   logic pop;

   //////////////////////////////
   // Status from the count
   //////////////////////////////

   assign o_full      = (count == CNT_W'(DEPTH));
   assign o_pop_valid = (count != '0);

   // Head shows without a clock (fall-through)
   assign o_pop_op = mem[rd_ptr];

   assign push = i_push_valid && !o_full;
   assign pop  = i_pop_ready && o_pop_valid;

   //////////////////////////////
   // Pointers and count
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Explicit wrap, DEPTH need not be a power of two
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves count alone
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   // Entry write
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= i_push_op;
      end
   end

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              i_pop_valid,
   input  cpu_pkg::exec_op_t i_pop_op,
   output logic              o_pop_ready,
   input  logic              i_out_ack,
   output logic              o_out_req,
   output cpu_pkg::word_t    o_out_data,
   output logic              o_halted,
   output cpu_pkg::word_t    o_num_inst
);

   // Output port handshake states
   localparam logic [1:0] OUT_IDLE    = 2'd0;
   localparam logic [1:0] OUT_WAIT_HI = 2'd1;
   localparam logic [1:0] OUT_WAIT_LO = 2'd2;

   // Register file
   cpu_pkg::word_t rf [cpu_pkg::NUM_REGS];

   // EX stage
   logic              ex_valid;
   cpu_pkg::exec_op_t ex_op;

   // WB stage
   logic              wb_valid;
   logic              wb_reg_write;
   logic              wb_halt;
   cpu_pkg::reg_idx_t wb_write_reg;
   cpu_pkg::word_t    wb_result;

   logic [1:0] out_state;

   // Operands and result
   cpu_pkg::word_t opnd_a;
   cpu_pkg::word_t rt_val;
   cpu_pkg::word_t opnd_b;
   cpu_pkg::word_t alu_result;

   logic fwd_rs;
   logic fwd_rt;
   logic wwd_done;
   logic ex_advance;
   logic halt_block;
   logic pop_fire;

   //////////////////////////////
   // EX operands with forwarding
   //////////////////////////////

   // WB result overrides the file read
   assign fwd_rs = wb_valid && wb_reg_write && (wb_write_reg == ex_op.rs);
   assign fwd_rt = wb_valid && wb_reg_write && (wb_write_reg == ex_op.rt);

   assign opnd_a = fwd_rs ? wb_result : rf[ex_op.rs];
   assign rt_val = fwd_rt ? wb_result : rf[ex_op.rt];
   assign opnd_b = ex_op.use_imm ? ex_op.imm : rt_val;

   // ALU
   always_comb begin
      case (ex_op.alu_op)
         cpu_pkg::ALU_ADD:    alu_result = opnd_a + opnd_b;
         cpu_pkg::ALU_SUB:    alu_result = opnd_a - opnd_b;
         cpu_pkg::ALU_AND:    alu_result = opnd_a & opnd_b;
         cpu_pkg::ALU_OR:     alu_result = opnd_a | opnd_b;
         // Single-operand ops use rs
         cpu_pkg::ALU_NOT:    alu_result = ~opnd_a;
         cpu_pkg::ALU_TCP:    alu_result = ~opnd_a + 1'b1;
         // One-bit shifts, logical right
         cpu_pkg::ALU_SHL:    alu_result = opnd_a << 1;
         cpu_pkg::ALU_SHR:    alu_result = opnd_a >> 1;
         cpu_pkg::ALU_PASS_B: alu_result = opnd_b;
         default:             alu_result = '0;
      endcase
   end

   //////////////////////////////
   // Stall and pop control
   //////////////////////////////

   // WWD finishes on the edge that sees ack fall
   assign wwd_done   = (out_state == OUT_WAIT_LO) && !i_out_ack;
   assign ex_advance = !(ex_valid && ex_op.is_output) || wwd_done;

   // Nothing behind an HLT enters the pipe
   assign halt_block = o_halted || (ex_valid && ex_op.is_halt) || (wb_valid && wb_halt);

   assign o_pop_ready = ex_advance && !halt_block;
   assign pop_fire    = i_pop_valid && o_pop_ready;

   // Stage valid bits
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ex_valid <= 1'b0;
         wb_valid <= 1'b0;
      end else begin
         if (ex_advance) begin
            ex_valid <= pop_fire;
         end
         // Held WWD sends bubbles into WB
         wb_valid <= ex_valid && ex_advance;
      end
   end

   // Stage payload, qualified by the valid bits
   always_ff @(posedge clk) begin
      if (pop_fire) begin
         ex_op <= i_pop_op;
      end
      wb_reg_write <= ex_op.reg_write;
      wb_halt      <= ex_op.is_halt;
      wb_write_reg <= ex_op.write_reg;
      wb_result    <= alu_result;
   end

   // Write-back
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            rf[i] <= '0;
         end
      end else if (wb_valid && wb_reg_write) begin
         rf[wb_write_reg] <= wb_result;
      end
   end

   //////////////////////////////
   // Output port
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         out_state <= OUT_IDLE;
         o_out_req <= 1'b0;
      end else begin
         case (out_state)
            OUT_IDLE: begin
               // req one cycle after WWD enters EX
               if (ex_valid && ex_op.is_output) begin
                  o_out_req <= 1'b1;
                  out_state <= OUT_WAIT_HI;
               end
            end
            OUT_WAIT_HI: begin
               if (i_out_ack) begin
                  o_out_req <= 1'b0;
                  out_state <= OUT_WAIT_LO;
               end
            end
            OUT_WAIT_LO: begin
               if (!i_out_ack) begin
                  out_state <= OUT_IDLE;
               end
            end
            default: out_state <= OUT_IDLE;
         endcase
      end
   end

   // Data latched with req, steady until the next WWD
   always_ff @(posedge clk) begin
      if (out_state == OUT_IDLE && ex_valid && ex_op.is_output) begin
         o_out_data <= opnd_a;
      end
   end

   //////////////////////////////
   // Halt and retire count
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_halted   <= 1'b0;
         o_num_inst <= '0;
      end else begin
         // Every valid WB op retires, HLT included
         if (wb_valid) begin
            o_num_inst <= o_num_inst + 1'b1;
         end
         // Sticky until reset
         if (wb_valid && wb_halt) begin
            o_halted <= 1'b1;
         end
      end
   end

endmodule

// File: files.f
cpu_pkg.sv
inst_decoder.sv
decode_queue.sv
exec_unit.sv
cpu_core.sv
tb_clock.sv
cpu_chk.sv
tb_cpu.sv

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              i_inst_req,
   input  cpu_pkg::inst_u    i_inst,
   input  logic              i_full,
   output logic              o_inst_ack,
   output logic              o_push_valid,
   output cpu_pkg::exec_op_t o_push_op
);

   // Word decodes to a real operation
   logic known;

   //////////////////////////////
   // Decode
   //////////////////////////////

   always_comb begin
      o_push_op = '0;
      known     = 1'b1;
      // Source fields sit in the same bits in both formats
      o_push_op.rs = i_inst.r.rs;
      o_push_op.rt = i_inst.r.rt;
      case (i_inst.r.opcode)
         cpu_pkg::OP_ADI: begin
            // Sign-extended immediate, result to rt
            o_push_op.alu_op    = cpu_pkg::ALU_ADD;
            o_push_op.write_reg = i_inst.i.rt;
            o_push_op.reg_write = 1'b1;
            o_push_op.use_imm   = 1'b1;
            o_push_op.imm       = {{8{i_inst.i.imm8[7]}}, i_inst.i.imm8};
         end
         cpu_pkg::OP_ORI: begin
            // Zero-extended immediate
            o_push_op.alu_op    = cpu_pkg::ALU_OR;
            o_push_op.write_reg = i_inst.i.rt;
            o_push_op.reg_write = 1'b1;
            o_push_op.use_imm   = 1'b1;
            o_push_op.imm       = {8'h00, i_inst.i.imm8};
         end
         cpu_pkg::OP_LHI: begin
            // Upper byte load, ALU just passes B through
            o_push_op.alu_op    = cpu_pkg::ALU_PASS_B;
            o_push_op.write_reg = i_inst.i.rt;
            o_push_op.reg_write = 1'b1;
            o_push_op.use_imm   = 1'b1;
            o_push_op.imm       = {i_inst.i.imm8, 8'h00};
         end
         cpu_pkg::OP_RTYPE: begin
            // R-type writes rd by default
            o_push_op.write_reg = i_inst.r.rd;
            o_push_op.reg_write = 1'b1;
            case (i_inst.r.func)
               cpu_pkg::FN_ADD: o_push_op.alu_op = cpu_pkg::ALU_ADD;
               cpu_pkg::FN_SUB: o_push_op.alu_op = cpu_pkg::ALU_SUB;
               cpu_pkg::FN_AND: o_push_op.alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::FN_ORR: o_push_op.alu_op = cpu_pkg::ALU_OR;
               cpu_pkg::FN_NOT: o_push_op.alu_op = cpu_pkg::ALU_NOT;
               cpu_pkg::FN_TCP: o_push_op.alu_op = cpu_pkg::ALU_TCP;
               cpu_pkg::FN_SHL: o_push_op.alu_op = cpu_pkg::ALU_SHL;
               cpu_pkg::FN_SHR: o_push_op.alu_op = cpu_pkg::ALU_SHR;
               cpu_pkg::FN_WWD: begin
                  // rs goes to the output port, no write-back
                  o_push_op.reg_write = 1'b0;
                  o_push_op.is_output = 1'b1;
               end
               cpu_pkg::FN_HLT: begin
                  o_push_op.reg_write = 1'b0;
                  o_push_op.is_halt   = 1'b1;
               end
               default: known = 1'b0;
            endcase
         end
         default: known = 1'b0;
      endcase
   end

   //////////////////////////////
   // Four-phase input side
   //////////////////////////////

   // Offer the op only in phase 1, queue drops it when full
   assign o_push_valid = i_inst_req && !o_inst_ack && known;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_inst_ack <= 1'b0;
      end else if (!i_inst_req) begin
         // Phase 4
         o_inst_ack <= 1'b0;
      end else if (!i_full) begin
         // Phase 2, same edge as the push
         // Unknown words get acked too
         o_inst_ack <= 1'b1;
      end
   end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_cpu -f files.f > build.log 2>&1 \
   && ./obj_dir/Vtb_cpu > sim.log 2>&1 \
   || { cat build.log; echo "CHECKS FAILED" >> sim.log; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic o_clk,
   output logic o_reset_n
);

   // 100 MHz clock
   initial begin
      o_clk = 1'b0;
      forever #5 o_clk = ~o_clk;
   end

   // Reset low for three rising edges
   initial begin
      o_reset_n = 1'b0;
      repeat (3) @(posedge o_clk);
      o_reset_n <= 1'b1;
   end

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

   // One program step and what it should produce
   typedef struct packed {
      cpu_pkg::inst_u inst;
      logic           has_out;
      logic           retires;
      cpu_pkg::word_t exp_data;
   } row_t;

   localparam logic [31:0] SEED = 32'hbc9f72c0;

   logic           clk;
   logic           reset_n;
   logic           i_inst_req;
   cpu_pkg::inst_u i_inst;
   logic           o_inst_ack;
   logic           o_out_req;
   cpu_pkg::word_t o_out_data;
   logic           i_out_ack;
   logic           o_halted;
   cpu_pkg::word_t o_num_inst;

   row_t           rows [$];
   cpu_pkg::word_t exp_out [$];
   int             cycle_limit = 1000;
   int             cycles = 0;
   int             ack_rises = 0;
   logic           ack_prev = 1'b0;
   int             outputs_seen = 0;
   int             outputs_exp = 0;
   logic [31:0]    out_rng;

   tb_clock i_tb_clock (
      .o_clk     (clk),
      .o_reset_n (reset_n)
   );

   cpu_core #(
      .QUEUE_DEPTH (cpu_pkg::QUEUE_DEPTH_DEFAULT)
   ) i_cpu_core (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_inst_req (i_inst_req),
      .i_inst     (i_inst),
      .o_inst_ack (o_inst_ack),
      .o_out_req  (o_out_req),
      .o_out_data (o_out_data),
      .i_out_ack  (i_out_ack),
      .o_halted   (o_halted),
      .o_num_inst (o_num_inst)
   );

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic cpu_pkg::inst_u encode_r(input cpu_pkg::reg_idx_t rs,
                                               input cpu_pkg::reg_idx_t rt,
                                               input cpu_pkg::reg_idx_t rd,
                                               input cpu_pkg::func_t    fn);
      cpu_pkg::inst_u w;
      w.r.opcode = cpu_pkg::OP_RTYPE;
      w.r.rs     = rs;
      w.r.rt     = rt;
      w.r.rd     = rd;
      w.r.func   = fn;
      return w;
   endfunction

   function automatic cpu_pkg::inst_u encode_i(input cpu_pkg::opcode_t  op,
                                               input cpu_pkg::reg_idx_t rs,
                                               input cpu_pkg::reg_idx_t rt,
                                               input logic [7:0]        imm8);
      cpu_pkg::inst_u w;
      w.i.opcode = op;
      w.i.rs     = rs;
      w.i.rt     = rt;
      w.i.imm8   = imm8;
      return w;
   endfunction

   task automatic stop_on_failure();
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input cpu_pkg::word_t expected,
                             input cpu_pkg::word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns %s expected %h got %h", $time, name, expected, actual);
         stop_on_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns %s expected %b got %b", $time, name, expected, actual);
         stop_on_failure();
      end
   endtask

   task automatic add_row(input cpu_pkg::inst_u inst, input logic has_out,
                          input logic retires, input cpu_pkg::word_t exp_data);
      rows.push_back('{inst, has_out, retires, exp_data});
      if (has_out) begin
         exp_out.push_back(exp_data);
         outputs_exp++;
      end
   endtask

   //////////////////////////////
   // Program table
   //////////////////////////////

   // Expected values start from all-zero registers
   task automatic build_table();
      // Immediates build r0 = 0x1200 | 0x34
      add_row(encode_i(cpu_pkg::OP_LHI, 2'd0, 2'd0, 8'h12), 1'b0, 1'b1, 16'h0000);
      add_row(encode_i(cpu_pkg::OP_ORI, 2'd0, 2'd0, 8'h34), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd0, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h1234);
      // r1 = r0 - 1
      add_row(encode_i(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'hff), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd1, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h1233);
      // ORI zero-extends even with bit 7 set
      add_row(encode_i(cpu_pkg::OP_ORI, 2'd3, 2'd2, 8'h80), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd2, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h0080);
      add_row(encode_i(cpu_pkg::OP_ADI, 2'd2, 2'd3, 8'h7f), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd3, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h00ff);
      // Two-operand ALU ops with one destination each
      add_row(encode_r(2'd1, 2'd2, 2'd0, cpu_pkg::FN_ADD), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd0, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h12b3);
      add_row(encode_r(2'd0, 2'd3, 2'd1, cpu_pkg::FN_SUB), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd1, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h11b4);
      add_row(encode_r(2'd1, 2'd0, 2'd2, cpu_pkg::FN_AND), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd2, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h10b0);
      add_row(encode_r(2'd2, 2'd3, 2'd3, cpu_pkg::FN_ORR), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd3, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h10ff);
      // Unknown opcode and unknown func are acked but never retire
      add_row(cpu_pkg::inst_u'(16'h0123), 1'b0, 1'b0, 16'h0000);
      add_row(cpu_pkg::inst_u'(16'hf009), 1'b0, 1'b0, 16'h0000);
      // Single-operand ops
      add_row(encode_r(2'd3, 2'd0, 2'd0, cpu_pkg::FN_NOT), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd0, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'hef00);
      add_row(encode_r(2'd0, 2'd0, 2'd1, cpu_pkg::FN_TCP), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd1, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h1100);
      add_row(encode_r(2'd1, 2'd0, 2'd2, cpu_pkg::FN_SHL), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd2, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h2200);
      add_row(encode_r(2'd0, 2'd0, 2'd3, cpu_pkg::FN_SHR), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd3, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h7780);
      // Negative ADI gives 0x7780 - 0x80
      add_row(encode_i(cpu_pkg::OP_ADI, 2'd3, 2'd0, 8'h80), 1'b0, 1'b1, 16'h0000);
      add_row(encode_r(2'd0, 2'd0, 2'd0, cpu_pkg::FN_WWD), 1'b1, 1'b1, 16'h7700);
      add_row(encode_r(2'd0, 2'd0, 2'd0, cpu_pkg::FN_HLT), 1'b0, 1'b1, 16'h0000);
   endtask

   //////////////////////////////
   // Input side and verdict
   //////////////////////////////

   initial begin
      int             gap;
      logic [31:0]    in_rng;
      cpu_pkg::word_t retired_exp;
      i_inst_req  = 1'b0;
      i_inst      = '0;
      i_out_ack   = 1'b0;
      in_rng      = SEED;
      retired_exp = '0;
      build_table();
      cycle_limit = rows.size() * 40;
      foreach (rows[n]) begin
         if (rows[n].retires) begin
            retired_exp = retired_exp + 16'd1;
         end
      end

      // Reset state
      wait (reset_n === 1'b1);
      @(negedge clk);
      check_flag("o_inst_ack", 1'b0, o_inst_ack);
      check_flag("o_out_req", 1'b0, o_out_req);
      check_flag("o_halted", 1'b0, o_halted);
      check_word("o_num_inst", 16'h0000, o_num_inst);

      // Four-phase source with a random idle gap before each req
      foreach (rows[n]) begin
         in_rng = lcg_step(in_rng);
         gap    = int'(in_rng[31:30]);
         repeat (gap) @(posedge clk);
         @(posedge clk);
         i_inst_req <= 1'b1;
         i_inst     <= rows[n].inst;
         @(negedge clk);
         while (!o_inst_ack) @(negedge clk);
         @(posedge clk);
         i_inst_req <= 1'b0;
         @(negedge clk);
         while (o_inst_ack) @(negedge clk);
      end

      // Last row is HLT
      while (!o_halted) @(negedge clk);
      check_word("o_num_inst", retired_exp, o_num_inst);
      repeat (5) begin
         @(negedge clk);
         check_flag("o_halted", 1'b1, o_halted);
         check_flag("o_out_req", 1'b0, o_out_req);
         check_word("o_num_inst", retired_exp, o_num_inst);
      end
      check_word("inst ack count", cpu_pkg::word_t'(rows.size()), cpu_pkg::word_t'(ack_rises));
      check_word("output count", cpu_pkg::word_t'(outputs_exp),
                 cpu_pkg::word_t'(outputs_seen));
      // Handshake assertions in the bound checker
      if (i_cpu_core.i_cpu_chk.fail_count == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         $display("Handshake assertions failed %0d times during the run",
                  i_cpu_core.i_cpu_chk.fail_count);
         stop_on_failure();
      end
   end

   //////////////////////////////
   // Output sink
   //////////////////////////////

   // Acks each WWD after 0 to 7 idle cycles
   initial begin
      int             delay;
      cpu_pkg::word_t expected;
      out_rng = ~SEED;
      wait (reset_n === 1'b1);
      forever begin
         @(negedge clk);
         while (!o_out_req) @(negedge clk);
         if (exp_out.size() == 0) begin
            $display("Output port sent a word that no table row expects");
            stop_on_failure();
         end
         expected = exp_out.pop_front();
         check_word("o_out_data", expected, o_out_data);
         out_rng = lcg_step(out_rng);
         delay   = int'(out_rng[31:29]);
         repeat (delay) @(posedge clk);
         @(posedge clk);
         i_out_ack <= 1'b1;
         @(negedge clk);
         while (o_out_req) @(negedge clk);
         @(posedge clk);
         i_out_ack <= 1'b0;
         outputs_seen++;
      end
   end

   // Counts ack rising edges for the per-word total
   always @(negedge clk) begin
      if (reset_n) begin
         if (o_inst_ack && !ack_prev) begin
            ack_rises <= ack_rises + 1;
         end
         ack_prev <= o_inst_ack;
      end
   end

   // Run length guard
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Run timed out after %0d cycles without reaching halt", cycles);
         stop_on_failure();
      end
   end

endmodule
